// File: Makefile
TOP = rgbwLampCtrl_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f $(wildcard logic/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir $(LOG)

// File: logic/colorGen.sv
/*
 * colorGen
 * Per-channel colour generator: fetches its settings, walks the colour wheel
 * or passes direct values, adds white and dims the result.
 */
`timescale 1ns/100ps
`default_nettype none

module colorGen (
    input  wire                    clk,
    input  wire                    reset_sig,
    input  wire regMapPkg::chanSel chan,
    output logic                   req,
    output regMapPkg::regAddr      rdAddr,
    input  wire                    grant,
    input  wire [7:0]              rdData,
    output lampPkg::rgbwPixel      pixel,
    output logic                   pixelValid
);

    import lampPkg::*;
    import regMapPkg::*;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DRAIN,
        DISPATCH,
        STEP,
        WADD,
        DIM
    } genState;

    genState     state;
    chanSettings settings;
    logic [2:0]  wordIdx;
    logic [2:0]  capIdx;
    logic        capValid;

    logic [7:0]  hueIdx;
    logic [7:0]  hueTarget;
    logic [2:0]  seg;
    logic [5:0]  segPos;
    logic [7:0]  ramp;
    rgbwPixel    wheel;
    rgbwPixel    mix;
    logic [2:0]  shift;

    function automatic logic [7:0] satAdd(input logic [7:0] a, input logic [7:0] b);
        logic [8:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[8] ? 8'hFF : sum[7:0];
    endfunction

    // wheel colour for a segment and ramp value, white left at zero
    function automatic rgbwPixel wheelColour(input logic [2:0] s, input logic [7:0] r);
        rgbwPixel c;
        c = '0;
        case (s)
            3'd0: begin
                c.red  = 8'hFF;
                c.blue = r;
            end
            3'd1: begin
                c.red  = 8'hFF - r;
                c.blue = 8'hFF;
            end
            3'd2: begin
                c.green = r;
                c.blue  = 8'hFF;
            end
            3'd3: begin
                c.green = 8'hFF;
                c.blue  = 8'hFF - r;
            end
            3'd4: begin
                c.red   = r;
                c.green = 8'hFF;
            end
            3'd5: begin
                c.red   = 8'hFF;
                c.green = 8'hFF - r;
            end
            default: c.red = 8'hFF;
        endcase
        return c;
    endfunction

    assign req       = (state == FETCH);
    assign rdAddr    = regAddr'(int'(chan) * REGS_PER_CHAN + int'(wordIdx));
    assign hueTarget = (settings.colorIdx > HUE_LIMIT) ? HUE_LIMIT : settings.colorIdx;
    assign shift     = settings.lint[7:5];
    assign wheel     = wheelColour(seg, ramp);

    // read data lands one cycle after the grant
    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            capValid <= 1'b0;
        end else begin
            capValid <= grant;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            capIdx <= wordIdx;
        end
        if (capValid) begin
            case (capIdx)
                REG_MODE:  settings.mode     <= rdData;
                REG_LINT:  settings.lint     <= rdData;
                REG_COLOR: settings.colorIdx <= rdData;
                REG_WHITE: settings.white    <= rdData;
                REG_RED:   settings.red      <= rdData;
                REG_GREEN: settings.green    <= rdData;
                REG_BLUE:  settings.blue     <= rdData;
                default:   settings.mode     <= settings.mode;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            state      <= IDLE;
            wordIdx    <= REG_MODE;
            hueIdx     <= 8'd0;
            seg        <= 3'd0;
            segPos     <= 6'd0;
            ramp       <= 8'd0;
            pixel      <= '0;
            pixelValid <= 1'b0;
        end else begin
            pixelValid <= 1'b0;
            case (state)
                IDLE: state <= FETCH;

                // stall here until each word is granted
                FETCH: begin
                    if (grant) begin
                        if (wordIdx == REG_BLUE) begin
                            wordIdx <= REG_MODE;
                            state   <= DRAIN;
                        end else begin
                            wordIdx <= wordIdx + 3'd1;
                        end
                    end
                end

                DRAIN: state <= DISPATCH;

                DISPATCH: begin
                    hueIdx <= 8'd0;
                    seg    <= 3'd0;
                    segPos <= 6'd0;
                    ramp   <= 8'd0;
                    if (settings.mode == MODE_DIRECT) begin
                        pixel.red   <= settings.red;
                        pixel.green <= settings.green;
                        pixel.blue  <= settings.blue;
                        pixel.white <= settings.white;
                        pixelValid  <= 1'b1;
                        state       <= FETCH;
                    end else if (settings.mode == MODE_HUE) begin
                        state <= STEP;
                    end else begin
                        // unknown mode keeps the old pixel
                        state <= FETCH;
                    end
                end

                // one wheel index per cycle
                STEP: begin
                    if (hueIdx == hueTarget) begin
                        state <= WADD;
                    end else begin
                        hueIdx <= hueIdx + 8'd1;
                        if (segPos == SEG_LEN - 6'd1) begin
                            segPos <= 6'd0;
                            seg    <= seg + 3'd1;
                            ramp   <= 8'd0;
                        end else begin
                            segPos <= segPos + 6'd1;
                            ramp   <= ramp + HUE_STEP;
                        end
                    end
                end

                WADD: begin
                    mix.red   <= satAdd(wheel.red, settings.white);
                    mix.green <= satAdd(wheel.green, settings.white);
                    mix.blue  <= satAdd(wheel.blue, settings.white);
                    mix.white <= settings.white;
                    state     <= DIM;
                end

                DIM: begin
                    pixel.red   <= mix.red >> shift;
                    pixel.green <= mix.green >> shift;
                    pixel.blue  <= mix.blue >> shift;
                    pixel.white <= mix.white >> shift;
                    pixelValid  <= 1'b1;
                    state       <= FETCH;
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/lampPkg.sv
/*
 * lampPkg
 * Colour types, mode codes and colour-wheel constants for the lamp controller.
 */
`default_nettype none

package lampPkg;

    // one RGBW output pixel
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic [7:0] white;
    } rgbwPixel;

    // settings block of one channel, in register order
    typedef struct packed {
        logic [7:0] mode;
        logic [7:0] lint;
        logic [7:0] colorIdx;
        logic [7:0] white;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } chanSettings;

    // mode codes
    localparam logic [7:0] MODE_DIRECT = 8'h21;
    localparam logic [7:0] MODE_HUE    = 8'hA4;

    // colour wheel
    localparam logic [7:0] HUE_STEP  = 8'd7;
    localparam logic [5:0] SEG_LEN   = 6'd36;
    localparam logic [7:0] HUE_LIMIT = 8'd216;

endpackage

`default_nettype wire

// File: logic/paramRegs.sv
/*
 * paramRegs
 * Settings memory of 32 bytes with a host write port and one shared read port.
 */
`timescale 1ns/100ps
`default_nettype none

module paramRegs (
    input  wire                clk,
    input  wire                reset_sig,
    input  wire regMapPkg::hostWrite wr,
    input  wire regMapPkg::regAddr   rdAddr,
    output logic [7:0]         rdData
);

    logic [7:0] mem [2 ** $bits(rdAddr)];

    // host port, never arbitrated
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read
    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            rdData <= 8'h00;
        end else begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

// File: logic/pwmDriver.sv
/*
 * pwmDriver
 * Four-output 8-bit PWM with a 255-cycle period; new pixels apply at period start.
 */
`timescale 1ns/100ps
`default_nettype none

module pwmDriver (
    input  wire                    clk,
    input  wire                    reset_sig,
    input  wire lampPkg::rgbwPixel pixel,
    output logic [3:0]             pwmOut
);

    import lampPkg::*;

    logic [7:0] periodCnt;
    rgbwPixel   work;

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            periodCnt <= 8'd0;
            work      <= '0;
        end else if (periodCnt == 8'd254) begin
            periodCnt <= 8'd0;
            work      <= pixel;
        end else begin
            periodCnt <= periodCnt + 8'd1;
        end
    end

    // bit 3 red down to bit 0 white
    assign pwmOut[3] = periodCnt < work.red;
    assign pwmOut[2] = periodCnt < work.green;
    assign pwmOut[1] = periodCnt < work.blue;
    assign pwmOut[0] = periodCnt < work.white;

endmodule

`default_nettype wire

// File: logic/regArbiter.sv
/*
 * regArbiter
 * Round-robin arbiter giving the colour generators turns on the shared read port.
 */
`timescale 1ns/100ps
`default_nettype none

module regArbiter (
    input  wire                                 clk,
    input  wire                                 reset_sig,
    input  wire [regMapPkg::NUM_CHANNELS-1:0]   req,
    input  wire regMapPkg::regAddr              reqAddr [regMapPkg::NUM_CHANNELS],
    output logic [regMapPkg::NUM_CHANNELS-1:0]  grant,
    output regMapPkg::regAddr                   memAddr
);

    import regMapPkg::*;

    chanSel lastGrant;
    chanSel winner;

    // search starts at the channel after the last one served
    always_comb begin
        int   cand;
        logic found;
        grant  = '0;
        winner = lastGrant;
        found  = 1'b0;
        for (int off = 1; off <= NUM_CHANNELS; off++) begin
            cand = (int'(lastGrant) + off) % NUM_CHANNELS;
            if (!found && req[cand]) begin
                found       = 1'b1;
                winner      = chanSel'(cand);
                grant[cand] = 1'b1;
            end
        end
    end

    assign memAddr = reqAddr[winner];

    always_ff @(posedge clk) begin
        if (!reset_sig) begin
            // channel 0 goes first
            lastGrant <= chanSel'(NUM_CHANNELS - 1);
        end else if (|grant) begin
            lastGrant <= winner;
        end
    end

endmodule

`default_nettype wire

// File: logic/regMapPkg.sv
/*
 * regMapPkg
 * Register map, channel count and address types of the settings memory.
 */
`default_nettype none

package regMapPkg;

    localparam int NUM_CHANNELS  = 3;
    localparam int REGS_PER_CHAN = 8;

    typedef logic [4:0] regAddr;
    typedef logic [1:0] chanSel;

    // word offsets inside a channel block, offset 7 reserved
    localparam logic [2:0] REG_MODE  = 3'd0;
    localparam logic [2:0] REG_LINT  = 3'd1;
    localparam logic [2:0] REG_COLOR = 3'd2;
    localparam logic [2:0] REG_WHITE = 3'd3;
    localparam logic [2:0] REG_RED   = 3'd4;
    localparam logic [2:0] REG_GREEN = 3'd5;
    localparam logic [2:0] REG_BLUE  = 3'd6;

    // host write strobe
    typedef struct packed {
        logic       en;
        regAddr     addr;
        logic [7:0] data;
    } hostWrite;

endpackage

`default_nettype wire

// File: logic/rgbwLampCtrl.sv
/*
 * rgbwLampCtrl
 * Three-channel RGBW lamp controller: settings memory, arbiter, generators, PWM.
 */
`timescale 1ns/100ps
`default_nettype none

module rgbwLampCtrl (
    input  wire                                clk,
    input  wire                                reset_sig,
    input  wire regMapPkg::hostWrite           wr,
    output lampPkg::rgbwPixel                  pixels [regMapPkg::NUM_CHANNELS],
    output logic [regMapPkg::NUM_CHANNELS-1:0] pixelValid,
    output logic [3:0]                         pwmOut [regMapPkg::NUM_CHANNELS]
);

    import regMapPkg::*;

    logic [NUM_CHANNELS-1:0] req;
    logic [NUM_CHANNELS-1:0] grant;
    regAddr                  reqAddr [NUM_CHANNELS];
    regAddr                  memAddr;
    logic [7:0]              rdData;

    paramRegs regs0 (
        .clk       (clk),
        .reset_sig (reset_sig),
        .wr        (wr),
        .rdAddr    (memAddr),
        .rdData    (rdData)
    );

    regArbiter arb0 (
        .clk       (clk),
        .reset_sig (reset_sig),
        .req       (req),
        .reqAddr   (reqAddr),
        .grant     (grant),
        .memAddr   (memAddr)
    );

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : gChan
        colorGen gen (
            .clk        (clk),
            .reset_sig  (reset_sig),
            .chan       (chanSel'(i)),
            .req        (req[i]),
            .rdAddr     (reqAddr[i]),
            .grant      (grant[i]),
            .rdData     (rdData),
            .pixel      (pixels[i]),
            .pixelValid (pixelValid[i])
        );

        pwmDriver pwm (
            .clk       (clk),
            .reset_sig (reset_sig),
            .pixel     (pixels[i]),
            .pwmOut    (pwmOut[i])
        );
    end

endmodule

`default_nettype wire

// File: src.f
logic/lampPkg.sv
logic/regMapPkg.sv
logic/paramRegs.sv
logic/regArbiter.sv
logic/colorGen.sv
logic/pwmDriver.sv
logic/rgbwLampCtrl.sv
verif/rgbwLampCtrl_tb.sv

// File: verif/lamp_testdata.txt
# name chan mode(hex) lint color white red green blue | expected red green blue white
# mode 21 direct, a4 hue, other codes keep the old pixel; all other columns decimal
direct_basic    0 21   0   0  40 200 100  50   200 100  50  40
direct_keep     0 55   0   0  40 200 100  50   200 100  50  40
hue_seg0_start  1 a4   0   0   0   0   0   0   255   0   0   0
hue_seg0_mid    1 a4   0  20   0   0   0   0   255   0 140   0
hue_seg0_end    2 a4   0  35   0   0   0   0   255   0 245   0
hue_seg1_start  2 a4   0  36   0   0   0   0   255   0 255   0
hue_seg1_mid    1 a4   0  50   0   0   0   0   157   0 255   0
hue_seg2_start  0 a4   0  72   0   0   0   0     0   0 255   0
hue_seg2_mid    2 a4   0 100   0   0   0   0     0 196 255   0
hue_seg3_start  1 a4   0 108   0   0   0   0     0 255 255   0
hue_seg3_end    0 a4   0 143   0   0   0   0     0 255  10   0
hue_seg4_mid    2 a4   0 160   0   0   0   0   112 255   0   0
hue_seg5_start  1 a4   0 180   0   0   0   0   255 255   0   0
hue_seg5_end    0 a4   0 215   0   0   0   0   255  10   0   0
hue_limit       2 a4   0 216   0   0   0   0   255   0   0   0
hue_over_limit  1 a4   0 250   0   0   0   0   255   0   0   0
white_small     0 a4   0 100  20   0   0   0    20 216 255  20
white_large     2 a4   0  50 200   0   0   0   255 200 255 200
white_full      1 a4   0  20 255   0   0   0   255 255 255 255
dim_shift0      0 a4  31 100  20   0   0   0    20 216 255  20
dim_shift1      1 a4  37 100  20   0   0   0    10 108 127  10
dim_shift2      2 a4  64 100  20   0   0   0     5  54  63   5
dim_shift3      0 a4 127 100  20   0   0   0     2  27  31   2
dim_shift4      1 a4 128 100  20   0   0   0     1  13  15   1
dim_shift5      2 a4 160 100  20   0   0   0     0   6   7   0
dim_shift6      0 a4 192 100  20   0   0   0     0   3   3   0
dim_shift7      1 a4 224 100  20   0   0   0     0   1   1   0
shared_ch0      0 21   0   0  64  10 128 255    10 128 255  64
shared_ch1      1 a4  32 160  30   0   0   0    71 127  15  15
shared_ch2      2 a4   0  72   0   0   0   0     0   0 255   0

// File: verif/rgbwLampCtrl_tb.sv
/*
 * rgbwLampCtrl_tb
 * Writes channel settings from the test data file, checks pixels and PWM duty.
 */
`timescale 1ns/100ps
`default_nettype none

module rgbwLampCtrl_tb;

    import lampPkg::*;
    import regMapPkg::*;

    localparam int CYCLES_PER_REC  = 2000;
    localparam int PWM_TEST_CYCLES = 3000;
    localparam int PWM_PERIOD      = 255;
    localparam int KEEP_SETTLE     = 300;
    localparam int KEEP_WATCH      = 500;

    logic                    clk;
    logic                    reset_sig;
    hostWrite                wr;
    rgbwPixel                pixels [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] pixelValid;
    logic [3:0]              pwmOut [NUM_CHANNELS];

    string       recName [$];
    int          recChan [$];
    chanSettings recSet [$];
    rgbwPixel    recExp [$];
    rgbwPixel    lastExp [NUM_CHANNELS];

    int errCount   = 0;
    int checkCount = 0;
    int cycleCount = 0;
    int cycleLimit = PWM_TEST_CYCLES;

    rgbwLampCtrl dut0 (
        .clk        (clk),
        .reset_sig  (reset_sig),
        .wr         (wr),
        .pixels     (pixels),
        .pixelValid (pixelValid),
        .pwmOut     (pwmOut)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin
        wait (cycleCount >= cycleLimit);
        $display("timeout: run did not finish within %0d cycles", cycleLimit);
        $display("TEST FAIL");
        $finish;
    end

    task automatic checkValue(input string tname, input string what,
                              input int expected, input int actual);
        checkCount++;
        assert (actual == expected) else begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     tname, what, expected, actual);
            errCount++;
        end
    endtask

    task automatic checkPixel(input string tname, input rgbwPixel expected,
                              input rgbwPixel actual);
        checkValue(tname, "red", int'(expected.red), int'(actual.red));
        checkValue(tname, "green", int'(expected.green), int'(actual.green));
        checkValue(tname, "blue", int'(expected.blue), int'(actual.blue));
        checkValue(tname, "white", int'(expected.white), int'(actual.white));
    endtask

    task automatic writeReg(input int ch, input logic [2:0] offset, input logic [7:0] data);
        wr.en   = 1'b1;
        wr.addr = regAddr'(ch * REGS_PER_CHAN + int'(offset));
        wr.data = data;
        @(negedge clk);
    endtask

    // one register per falling edge, then the strobe drops
    task automatic writeChannel(input int ch, input chanSettings s);
        writeReg(ch, REG_MODE, s.mode);
        writeReg(ch, REG_LINT, s.lint);
        writeReg(ch, REG_COLOR, s.colorIdx);
        writeReg(ch, REG_WHITE, s.white);
        writeReg(ch, REG_RED, s.red);
        writeReg(ch, REG_GREEN, s.green);
        writeReg(ch, REG_BLUE, s.blue);
        wr = '0;
    endtask

    task automatic waitPulses(input int ch, input int count);
        int seen;
        seen = 0;
        while (seen < count) begin
            @(negedge clk);
            if (pixelValid[ch]) seen++;
        end
    endtask

    task automatic countPulses(input int ch, input int cycles, output int pulses);
        pulses = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (pixelValid[ch]) pulses++;
        end
    endtask

    task automatic loadRecords();
        int          fd;
        int          n;
        int          f [12];
        string       line;
        string       tname;
        chanSettings s;
        rgbwPixel    e;
        fd = $fopen("verif/lamp_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file verif/lamp_testdata.txt");
            errCount++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%s %d %h %d %d %d %d %d %d %d %d %d %d", tname,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                            f[8], f[9], f[10], f[11]);
                if (n == 13) begin
                    s = {8'(f[1]), 8'(f[2]), 8'(f[3]), 8'(f[4]), 8'(f[5]), 8'(f[6]), 8'(f[7])};
                    e = {8'(f[8]), 8'(f[9]), 8'(f[10]), 8'(f[11])};
                    recName.push_back(tname);
                    recChan.push_back(f[0]);
                    recSet.push_back(s);
                    recExp.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic runRecord(input int i);
        int          ch;
        int          pulses;
        chanSettings s;
        ch = recChan[i];
        s  = recSet[i];
        writeChannel(ch, s);
        if (s.mode == MODE_DIRECT || s.mode == MODE_HUE) begin
            // second pulse ends a fetch that began after the writes
            waitPulses(ch, 2);
            checkPixel(recName[i], recExp[i], pixels[ch]);
            lastExp[ch] = recExp[i];
        end else begin
            // a pass that read the old mode may still finish
            repeat (KEEP_SETTLE) @(negedge clk);
            countPulses(ch, KEEP_WATCH, pulses);
            checkValue(recName[i], "pulses", 0, pulses);
            checkPixel(recName[i], recExp[i], pixels[ch]);
        end
    endtask

    // all channels running at once, each must hold its own pixel
    task automatic checkShared();
        int seen [NUM_CHANNELS];
        int done;
        foreach (seen[c]) seen[c] = 0;
        done = 0;
        while (done == 0) begin
            @(negedge clk);
            done = 1;
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                if (pixelValid[c]) seen[c]++;
                if (seen[c] < 2) done = 0;
            end
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            checkPixel($sformatf("shared_all_ch%0d", c), lastExp[c], pixels[c]);
        end
    endtask

    task automatic checkDuty();
        int    high [NUM_CHANNELS][4];
        string tname;
        // let a period boundary pick up the settled pixel
        repeat (PWM_PERIOD) @(negedge clk);
        foreach (high[c, b]) high[c][b] = 0;
        repeat (PWM_PERIOD) begin
            @(negedge clk);
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                for (int b = 0; b < 4; b++) begin
                    if (pwmOut[c][b]) high[c][b]++;
                end
            end
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            tname = $sformatf("pwm_ch%0d", c);
            checkValue(tname, "red duty", int'(lastExp[c].red), high[c][3]);
            checkValue(tname, "green duty", int'(lastExp[c].green), high[c][2]);
            checkValue(tname, "blue duty", int'(lastExp[c].blue), high[c][1]);
            checkValue(tname, "white duty", int'(lastExp[c].white), high[c][0]);
        end
    endtask

    initial begin
        reset_sig = 1'b0;
        wr        = '0;
        foreach (lastExp[c]) lastExp[c] = '0;
        loadRecords();
        if (recName.size() == 0) begin
            $display("no test records were read from the test data file");
            errCount++;
        end
        cycleLimit = recName.size() * CYCLES_PER_REC + PWM_TEST_CYCLES;
        repeat (2) @(negedge clk);
        reset_sig = 1'b1;
        foreach (recName[i]) runRecord(i);
        checkShared();
        checkDuty();
        $display("checks run: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
